// ==== asic_daq_top.f ====
source/asic_daq_pkg.sv
source/host_bus_slave.sv
source/register_banks.sv
source/command_pulser.sv
source/asic_readout.sv
source/readout_fifo.sv
source/asic_daq_top.sv
tb/asic_daq_tb.sv

// ==== Bender.yml ====
package:
  name: asic_daq

sources:
  - source/asic_daq_pkg.sv
  - source/host_bus_slave.sv
  - source/register_banks.sv
  - source/command_pulser.sv
  - source/asic_readout.sv
  - source/readout_fifo.sv
  - source/asic_daq_top.sv
  - target: simulation
    files:
      - tb/asic_daq_tb.sv

// ==== tb/asic_daq_tb.sv ====
`timescale 1ns/1ps

module asic_daq_tb;
	import asic_daq_pkg::*;

	localparam int clk_period    = 40;
	localparam int ack_limit     = 10; // cycles allowed per bus phase
	localparam int n_bursts      = 4;
	localparam int max_burst     = 6;
	localparam int n_pulses      = 16;
	localparam int n_packets     = 4;
	localparam int max_meat      = 4;
	localparam int n_overflow    = 40;
	localparam int n_extra_reads = 3;
	localparam int fifo_words    = 2**FIFO_DEPTH_LOG2;

	// start bit, 16 data bits and 3 idle cycles per serial word
	localparam int serial_bits = (n_packets * (max_meat + 4) + n_overflow) * 20;
	localparam int bus_phases  = (33 + 8 * 3 + 3)
		+ (33 + n_bursts * (1 + 2 * max_burst) + 33)
		+ n_pulses * 9
		+ (n_packets * (max_meat + 4) + 1) * 3
		+ (6 + fifo_words * 3 + n_extra_reads * 6);
	localparam longint watchdog_ns = longint'(serial_bits + bus_phases) * ack_limit * 2 * clk_period;

	logic                  sysclk;
	logic                  reset;
	logic                  register_select;
	logic                  read;
	logic                  enable;
	logic [BUS_WIDTH-1:0]  host_data_in;
	logic [BUS_WIDTH-1:0]  host_data_out;
	logic                  ack_valid;
	logic                  asic_data;
	asic_bias_t            bias;
	logic                  ls_i2c;
	command_pulses_t       commands;
	readout_flags_t        readout_flags;

	// ----------------------------------------
	// reference model
	logic [DATA_WIDTH-1:0] model_settings [16];
	logic [3:0]            model_flags; // dreset, legacy serial, i2c, trigger
	logic [7:0]            model_trigger_count;
	logic [BUS_WIDTH-1:0]  model_fifo [$];
	logic [7:0]            model_errors;
	logic                  model_in_packet;

	command_pulses_t       seen_commands;
	int                    pulse_cycles;
	readout_flags_t        seen_flags;
	int                    flag_cycles;
	string                 test_name;
	int                    errors;
	int                    checks;
	int                    tests_run;
	int                    tests_failed;
	int                    errors_at_start;
	logic [DATA_WIDTH-1:0] word;
	logic [DATA_WIDTH-1:0] count_before;
	command_pulses_t       expected_pulse;
	asic_bias_t            expected_bias;
	int unsigned           seed_dummy;
	int unsigned           offset;
	int unsigned           len;

	asic_daq_top i_asic_daq_top (
		.sysclk, .reset, .register_select, .read, .enable, .host_data_in,
		.host_data_out, .ack_valid, .asic_data, .bias, .ls_i2c, .commands, .readout_flags
	);

	initial begin
		sysclk = 1'b0;
		forever #(clk_period / 2) sysclk = ~sysclk;
	end

	// collects every command pulse between clears
	always @(negedge sysclk) begin
		if (commands != '0) begin
			seen_commands = seen_commands | commands;
			pulse_cycles  = pulse_cycles + 1;
		end
	end

	// same for the readout flags
	always @(negedge sysclk) begin
		if (readout_flags != '0) begin
			seen_flags  = seen_flags | readout_flags;
			flag_cycles = flag_cycles + 1;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the tests completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ----------------------------------------
	// checks and reporting
	task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch %s, %s: expected %h, actual %h", test_name, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic compare_bias(input string name, input asic_bias_t expected,
		input asic_bias_t actual);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch %s, %s: expected %h, actual %h", test_name, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic compare_commands(input string name, input command_pulses_t expected,
		input command_pulses_t actual);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch %s, %s: expected %b, actual %b", test_name, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic compare_flags(input string name, input readout_flags_t expected,
		input readout_flags_t actual);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch %s, %s: expected %b, actual %b", test_name, name,
				expected, actual);
			errors++;
		end
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
			tests_failed++;
		end
		errors_at_start = errors;
	endtask

	// ----------------------------------------
	// host bus, entered and left 2 ns after a rising edge
	task automatic bus_phase(input logic sel, input logic rd, input logic [BUS_WIDTH-1:0] data,
		output logic [BUS_WIDTH-1:0] rdata);
		int waited;
		register_select = sel;
		read            = rd;
		host_data_in    = data;
		enable          = 1'b1;
		waited          = 0;
		while (!ack_valid && waited < ack_limit) begin
			@(posedge sysclk);
			#2;
			waited++;
		end
		if (!ack_valid) begin
			$display("bus phase got no ack_valid within %0d cycles", ack_limit);
			errors++;
		end
		rdata  = host_data_out;
		enable = 1'b0;
		waited = 0;
		while (ack_valid && waited < ack_limit) begin
			@(posedge sysclk);
			#2;
			waited++;
		end
		if (ack_valid) begin
			$display("ack_valid stayed high after enable fell");
			errors++;
		end
	endtask

	task automatic bus_address(input logic [BANK_BITS-1:0] bank,
		input logic [OFFSET_BITS-1:0] reg_offset);
		logic [BUS_WIDTH-1:0] unused;
		bus_phase(1'b0, 1'b0, {bank, {(BUS_WIDTH-BANK_BITS-OFFSET_BITS){1'b0}}, reg_offset},
			unused);
	endtask

	task automatic bus_write_word(input logic [DATA_WIDTH-1:0] data);
		logic [BUS_WIDTH-1:0] unused;
		bus_phase(1'b1, 1'b0, data[DATA_WIDTH-1 -: BUS_WIDTH], unused); // upper half first
		bus_phase(1'b1, 1'b0, data[BUS_WIDTH-1:0], unused);
	endtask

	task automatic bus_read_word(output logic [DATA_WIDTH-1:0] data);
		logic [BUS_WIDTH-1:0] upper;
		logic [BUS_WIDTH-1:0] lower;
		bus_phase(1'b1, 1'b1, '0, upper);
		bus_phase(1'b1, 1'b1, '0, lower);
		data = {upper, lower};
	endtask

	task automatic read_register(input logic [BANK_BITS-1:0] bank,
		input logic [OFFSET_BITS-1:0] reg_offset, output logic [DATA_WIDTH-1:0] data);
		bus_address(bank, reg_offset);
		bus_read_word(data);
	endtask

	// ----------------------------------------
	// serial line and packet model
	task automatic send_asic_word(input logic [BUS_WIDTH-1:0] data);
		asic_data = 1'b1; // start bit
		@(posedge sysclk);
		#2;
		for (int i = BUS_WIDTH - 1; i >= 0; i--) begin
			asic_data = data[i];
			@(posedge sysclk);
			#2;
		end
		asic_data = 1'b0;
		repeat (3) begin
			@(posedge sysclk);
			#2;
		end
	endtask

	task automatic model_error();
		if (model_errors != 8'hFF) model_errors++;
	endtask

	task automatic model_receive(input logic [BUS_WIDTH-1:0] data,
		output readout_flags_t flags);
		logic keep;
		keep  = 1'b0;
		flags = '0;
		if (data == HEADER_WORD) begin
			model_in_packet = 1'b1;
			keep            = 1'b1;
			flags.header    = 1'b1;
		end else if (model_in_packet) begin
			keep = 1'b1;
			if (data == FOOTER_WORD) begin
				model_in_packet = 1'b0;
				flags.footer    = 1'b1;
			end else begin
				flags.meat = 1'b1;
			end
		end
		if (keep && model_fifo.size() < fifo_words) model_fifo.push_back(data);
		else if (keep) model_error(); // full, word lost
	endtask

	task automatic model_pop(output logic [DATA_WIDTH-1:0] data);
		if (model_fifo.size() == 0) begin
			model_error();
			data = '0;
		end else begin
			data = {{(DATA_WIDTH-BUS_WIDTH){1'b0}}, model_fifo.pop_front()};
		end
	endtask

	task automatic check_fifo_read(input string name);
		logic [DATA_WIDTH-1:0] expected;
		logic [DATA_WIDTH-1:0] actual;
		model_pop(expected);
		read_register(FIFO_DATA, 4'd0, actual);
		compare_word(name, expected, actual);
	endtask

	task automatic send_and_model(input logic [BUS_WIDTH-1:0] data);
		readout_flags_t expected_flags;
		seen_flags  = '0;
		flag_cycles = 0;
		send_asic_word(data);
		model_receive(data, expected_flags);
		compare_flags($sformatf("flags of word %h", data), expected_flags, seen_flags);
		compare_word($sformatf("flag cycles of word %h", data),
			(expected_flags != '0) ? 32'd1 : 32'd0, flag_cycles);
	endtask

	// ----------------------------------------
	initial begin
		reset           = 1'b1;
		register_select = 1'b0;
		read            = 1'b0;
		enable          = 1'b0;
		host_data_in    = '0;
		asic_data       = 1'b0;
		seed_dummy      = $urandom(56);
		errors          = 0;
		checks          = 0;
		tests_run       = 0;
		tests_failed    = 0;
		errors_at_start = 0;
		seen_commands   = '0;
		pulse_cycles    = 0;
		seen_flags      = '0;
		flag_cycles     = 0;
		test_name       = "";
		model_flags         = '0;
		model_trigger_count = '0;
		model_errors        = '0;
		model_in_packet     = 1'b0;
		for (int i = 0; i < 16; i++) model_settings[i] = '0;
		repeat (3) @(posedge sysclk);
		#2;
		reset = 1'b0;

		// 1: everything quiet after reset
		test_name = "reset_values";
		compare_bias("reset bias", '0, bias);
		compare_word("reset ls_i2c", '0, {31'b0, ls_i2c});
		bus_address(SETTINGS, 4'd0);
		for (int i = 0; i < 16; i++) begin
			bus_read_word(word);
			compare_word($sformatf("reset settings %0d", i), '0, word);
		end
		for (int i = 0; i < 8; i++) begin
			read_register(STATUS, i[3:0], word);
			compare_word($sformatf("reset status %0d", i), (i == 2) ? 32'd1 : 32'd0, word);
		end
		check_fifo_read("reset fifo read");
		end_test();

		// 2: bursts of settings writes with autoincrement
		test_name = "settings_writes";
		bus_address(SETTINGS, 4'd0);
		for (int i = 0; i < 16; i++) begin
			word = $urandom;
			bus_write_word(word);
			model_settings[i] = word;
		end
		for (int b = 0; b < n_bursts; b++) begin
			offset = $urandom_range(0, 15);
			len    = $urandom_range(1, max_burst);
			bus_address(SETTINGS, offset[3:0]);
			for (int i = 0; i < len; i++) begin
				word = $urandom;
				bus_write_word(word);
				model_settings[(offset + i) % 16] = word; // offset wraps at 16
			end
		end
		bus_address(SETTINGS, 4'd0);
		for (int i = 0; i < 16; i++) begin
			bus_read_word(word);
			compare_word($sformatf("settings %0d", i), model_settings[i], word);
		end
		end_test();

		// 3: bias outputs follow settings words 1 to 4
		test_name = "bias_outputs";
		expected_bias.cmp_bias = model_settings[1][11:0];
		expected_bias.isel     = model_settings[2][11:0];
		expected_bias.sb_bias  = model_settings[3][11:0];
		expected_bias.db_bias  = model_settings[4][11:0];
		compare_bias("bias", expected_bias, bias);
		compare_word("ls_i2c", {31'b0, model_settings[0][0]}, {31'b0, ls_i2c});
		end_test();

		// 4: command pulses, sticky flags and trigger count
		test_name = "command_pulses";
		for (int i = 0; i < n_pulses; i++) begin
			offset         = $urandom_range(0, 3);
			expected_pulse = '0;
			case (offset)
				0: expected_pulse.dreset        = 1'b1;
				1: expected_pulse.legacy_serial = 1'b1;
				2: expected_pulse.i2c_start     = 1'b1;
				default: expected_pulse.trigger = 1'b1;
			endcase
			model_flags[3 - offset] = 1'b1;
			if (offset == 3) model_trigger_count++;
			seen_commands = '0;
			pulse_cycles  = 0;
			bus_address(PULSES, offset[3:0]);
			bus_write_word($urandom);
			compare_commands($sformatf("pulse %0d", i), expected_pulse, seen_commands);
			compare_word($sformatf("pulse %0d cycles", i), 32'd1, pulse_cycles);
			read_register(STATUS, 4'd0, word);
			compare_word("status flags", {25'b0, model_flags, 3'b0}, word);
			read_register(STATUS, 4'd1, word);
			compare_word("trigger count", {24'b0, model_trigger_count}, word);
		end
		end_test();

		// 5: packets among stray words
		test_name = "packet_readout";
		for (int p = 0; p < n_packets; p++) begin
			len = $urandom_range(0, 2);
			for (int i = 0; i < len; i++) send_and_model($urandom);
			send_and_model(HEADER_WORD);
			len = $urandom_range(1, max_meat);
			for (int i = 0; i < len; i++) send_and_model($urandom);
			send_and_model(FOOTER_WORD);
		end
		send_and_model($urandom);
		len = model_fifo.size();
		for (int i = 0; i < len; i++) check_fifo_read($sformatf("packet word %0d", i));
		read_register(STATUS, 4'd2, word);
		compare_word("fifo empty after packets", 32'd1, word);
		end_test();

		// 6: overflow of an open packet, then underflow
		test_name = "overflow_underflow";
		read_register(STATUS, 4'd4, count_before);
		compare_word("error count before overflow", {24'b0, model_errors}, count_before);
		send_and_model(HEADER_WORD);
		for (int i = 1; i < n_overflow; i++) send_and_model($urandom);
		read_register(STATUS, 4'd4, word);
		compare_word("error count after overflow", {24'b0, model_errors}, word);
		compare_word("overflow errors", 32'd8, word - count_before);
		for (int i = 0; i < fifo_words; i++) check_fifo_read($sformatf("full fifo word %0d", i));
		for (int i = 0; i < n_extra_reads; i++) begin
			check_fifo_read($sformatf("empty fifo read %0d", i));
			read_register(STATUS, 4'd4, word);
			compare_word("error count after underflow", {24'b0, model_errors}, word);
		end
		end_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== source/asic_daq_top.sv ====
`timescale 1ns/1ps

module asic_daq_top (
	input  logic                               sysclk,
	input  logic                               reset,
	input  logic                               register_select,
	input  logic                               read,
	input  logic                               enable,
	input  logic [asic_daq_pkg::BUS_WIDTH-1:0] host_data_in,
	output logic [asic_daq_pkg::BUS_WIDTH-1:0] host_data_out,
	output logic                               ack_valid,
	input  logic                               asic_data,
	output asic_daq_pkg::asic_bias_t           bias,
	output logic                               ls_i2c,
	output asic_daq_pkg::command_pulses_t      commands,
	output asic_daq_pkg::readout_flags_t       readout_flags
);
	import asic_daq_pkg::*;

	reg_access_t              reg_access;
	logic [2**BANK_BITS-1:0]  write_strobe;
	logic [2**BANK_BITS-1:0]  read_strobe;
	logic [DATA_WIDTH-1:0]    read_data;
	command_pulses_t          pulse_requests;
	command_status_t          command_status;
	logic                     fifo_write;
	logic [BUS_WIDTH-1:0]     fifo_word_in;  // receiver to fifo
	logic [BUS_WIDTH-1:0]     fifo_head;     // fifo to read mux
	logic                     fifo_empty;
	logic [7:0]               fifo_error_count;
	logic                     fifo_pop;

	// ----------------------------------------
	// host side
	host_bus_slave i_host_bus_slave (
		.sysclk, .reset, .register_select, .read, .enable, .host_data_in,
		.host_data_out, .ack_valid, .reg_access, .write_strobe, .read_strobe, .read_data
	);

	register_banks i_register_banks (
		.sysclk, .reset, .reg_access, .write_strobe, .read_strobe, .read_data,
		.bias, .ls_i2c, .pulse_requests, .command_status,
		.fifo_word(fifo_head), .fifo_empty, .fifo_error_count, .fifo_pop
	);

	command_pulser i_command_pulser (
		.sysclk, .reset, .pulse_requests, .commands, .command_status
	);

	// ----------------------------------------
	// asic side
	asic_readout i_asic_readout (
		.sysclk, .reset, .asic_data, .fifo_write, .fifo_word(fifo_word_in),
		.flags(readout_flags)
	);

	readout_fifo i_readout_fifo (
		.sysclk, .reset, .write(fifo_write), .data_in(fifo_word_in), .pop(fifo_pop),
		.data_out(fifo_head), .empty(fifo_empty), .error_count(fifo_error_count)
	);

endmodule

// ==== source/readout_fifo.sv ====
`timescale 1ns/1ps

module readout_fifo (
	input  logic                               sysclk,
	input  logic                               reset,
	input  logic                               write,
	input  logic [asic_daq_pkg::BUS_WIDTH-1:0] data_in,
	input  logic                               pop,
	output logic [asic_daq_pkg::BUS_WIDTH-1:0] data_out,
	output logic                               empty,
	output logic [7:0]                         error_count
);
	import asic_daq_pkg::*;

	logic [BUS_WIDTH-1:0]     mem [2**FIFO_DEPTH_LOG2];
	logic [FIFO_DEPTH_LOG2:0] wr_ptr; // extra msb tells full from empty
	logic [FIFO_DEPTH_LOG2:0] rd_ptr;
	logic                     full;
	logic                     do_write;
	logic                     do_read;
	logic [1:0]               error_inc;
	logic [8:0]               error_sum;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
		(wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

	assign do_write = write && !full;
	assign do_read  = pop && !empty;

	// overflow and underflow can land in the same cycle
	assign error_inc = {1'b0, write && full} + {1'b0, pop && empty};
	assign error_sum = {1'b0, error_count} + {7'b0, error_inc};

	// fall through, zero when empty
	assign data_out = empty ? '0 : mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

	// ----------------------------------------
	always_ff @(posedge sysclk) begin
		if (do_write) begin
			mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= data_in;
		end
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			error_count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			error_count <= error_sum[8] ? 8'hFF : error_sum[7:0]; // saturates
		end
	end

endmodule

// ==== source/asic_readout.sv ====
`timescale 1ns/1ps

module asic_readout (
	input  logic                               sysclk,
	input  logic                               reset,
	input  logic                               asic_data,
	output logic                               fifo_write,
	output logic [asic_daq_pkg::BUS_WIDTH-1:0] fifo_word,
	output asic_daq_pkg::readout_flags_t       flags
);
	import asic_daq_pkg::*;

	readout_state_e               state;
	logic [BUS_WIDTH-1:0]         shift_reg;
	logic [$clog2(BUS_WIDTH)-1:0] bit_count;
	logic                         in_packet; // between header and footer

	// ----------------------------------------
	// start bit, 16 bits msb first, then one cycle in STORE
	// the line has to be low in the STORE cycle or the next start bit is missed
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state      <= HUNT;
			bit_count  <= '0;
			in_packet  <= 1'b0;
			fifo_write <= 1'b0;
			flags      <= '0;
		end else begin
			fifo_write <= 1'b0;
			flags      <= '0;
			case (state)
				HUNT: begin
					bit_count <= '0;
					if (asic_data) begin
						state <= SHIFT;
					end
				end
				SHIFT: begin
					bit_count <= bit_count + 1'b1;
					if (&bit_count) begin
						state <= STORE; // last bit sampled
					end
				end
				STORE: begin
					state <= HUNT;
					if (shift_reg == HEADER_WORD) begin
						in_packet    <= 1'b1; // a second header restarts the packet
						fifo_write   <= 1'b1;
						flags.header <= 1'b1;
					end else if (in_packet && shift_reg == FOOTER_WORD) begin
						in_packet    <= 1'b0;
						fifo_write   <= 1'b1;
						flags.footer <= 1'b1;
					end else if (in_packet) begin
						fifo_write <= 1'b1;
						flags.meat <= 1'b1;
					end
				end
				default: state <= HUNT;
			endcase
		end
	end

	// data path
	always_ff @(posedge sysclk) begin
		if (state == SHIFT) begin
			shift_reg <= {shift_reg[BUS_WIDTH-2:0], asic_data};
		end
		if (state == STORE) begin
			fifo_word <= shift_reg;
		end
	end

endmodule

// ==== source/command_pulser.sv ====
`timescale 1ns/1ps

module command_pulser (
	input  logic                          sysclk,
	input  logic                          reset,
	input  asic_daq_pkg::command_pulses_t pulse_requests,
	output asic_daq_pkg::command_pulses_t commands,
	output asic_daq_pkg::command_status_t command_status
);
	import asic_daq_pkg::*;

	// ----------------------------------------
	// one cycle command pulses
	always_ff @(posedge sysclk) begin
		if (reset) begin
			commands <= '0;
		end else begin
			commands <= pulse_requests;
		end
	end

	// sticky flags, set together with the pulse
	always_ff @(posedge sysclk) begin
		if (reset) begin
			command_status <= '0;
		end else begin
			if (pulse_requests.dreset) begin
				command_status.dreset_flag <= 1'b1;
			end
			if (pulse_requests.legacy_serial) begin
				command_status.legacy_serial_flag <= 1'b1;
			end
			if (pulse_requests.i2c_start) begin
				command_status.i2c_flag <= 1'b1;
			end
			if (pulse_requests.trigger) begin
				command_status.trigger_flag  <= 1'b1;
				command_status.trigger_count <= command_status.trigger_count + 1'b1; // wraps
			end
		end
	end

endmodule

// ==== source/register_banks.sv ====
`timescale 1ns/1ps

module register_banks (
	input  logic                                  sysclk,
	input  logic                                  reset,
	input  asic_daq_pkg::reg_access_t             reg_access,
	input  logic [2**asic_daq_pkg::BANK_BITS-1:0] write_strobe,
	input  logic [2**asic_daq_pkg::BANK_BITS-1:0] read_strobe,
	output logic [asic_daq_pkg::DATA_WIDTH-1:0]   read_data,
	output asic_daq_pkg::asic_bias_t              bias,
	output logic                                  ls_i2c,
	output asic_daq_pkg::command_pulses_t         pulse_requests,
	input  asic_daq_pkg::command_status_t         command_status,
	input  logic [asic_daq_pkg::BUS_WIDTH-1:0]    fifo_word,
	input  logic                                  fifo_empty,
	input  logic [7:0]                            fifo_error_count,
	output logic                                  fifo_pop
);
	import asic_daq_pkg::*;

	logic [DATA_WIDTH-1:0] settings [2**OFFSET_BITS];
	logic [DATA_WIDTH-1:0] status_word;

	// ----------------------------------------
	// settings bank
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < 2**OFFSET_BITS; i++) begin
				settings[i] <= '0;
			end
		end else if (write_strobe[SETTINGS]) begin
			settings[reg_access.offset] <= reg_access.write_data;
		end
	end

	assign ls_i2c        = settings[0][0]; // 0 = i2c, 1 = legacy serial
	assign bias.cmp_bias = settings[1][11:0];
	assign bias.isel     = settings[2][11:0];
	assign bias.sb_bias  = settings[3][11:0];
	assign bias.db_bias  = settings[4][11:0];

	// ----------------------------------------
	// status bank, read only
	always_comb begin
		status_word = '0;
		case (reg_access.offset)
			4'd0: status_word[6:3] = {command_status.dreset_flag,
				command_status.legacy_serial_flag, command_status.i2c_flag,
				command_status.trigger_flag};
			4'd1: status_word[7:0] = command_status.trigger_count;
			4'd2: status_word[0]   = fifo_empty;
			4'd4: status_word[7:0] = fifo_error_count;
			default: status_word = '0;
		endcase
	end

	// pulse bank, one cycle per write
	always_comb begin
		pulse_requests = '0;
		if (write_strobe[PULSES]) begin
			case (reg_access.offset)
				4'd0: pulse_requests.dreset        = 1'b1;
				4'd1: pulse_requests.legacy_serial = 1'b1;
				4'd2: pulse_requests.i2c_start     = 1'b1;
				4'd3: pulse_requests.trigger       = 1'b1;
				default: pulse_requests = '0;
			endcase
		end
	end

	assign fifo_pop = read_strobe[FIFO_DATA];

	// read mux
	always_comb begin
		case (bank_e'(reg_access.bank))
			SETTINGS:  read_data = settings[reg_access.offset];
			STATUS:    read_data = status_word;
			FIFO_DATA: read_data = {{(DATA_WIDTH-BUS_WIDTH){1'b0}}, fifo_word};
			default:   read_data = '0; // pulses and unused banks
		endcase
	end

endmodule

// ==== source/host_bus_slave.sv ====
`timescale 1ns/1ps

module host_bus_slave (
	input  logic                                  sysclk,
	input  logic                                  reset,
	input  logic                                  register_select, // 0 = address, 1 = data
	input  logic                                  read,            // 0 = write, 1 = read
	input  logic                                  enable,
	input  logic [asic_daq_pkg::BUS_WIDTH-1:0]    host_data_in,
	output logic [asic_daq_pkg::BUS_WIDTH-1:0]    host_data_out,
	output logic                                  ack_valid,
	output asic_daq_pkg::reg_access_t             reg_access,
	output logic [2**asic_daq_pkg::BANK_BITS-1:0] write_strobe,
	output logic [2**asic_daq_pkg::BANK_BITS-1:0] read_strobe,
	input  logic [asic_daq_pkg::DATA_WIDTH-1:0]   read_data
);
	import asic_daq_pkg::*;

	host_state_e            state;
	logic                   enable_meta;
	logic                   enable_sync;
	logic                   half; // 0 = upper half is next
	logic [BANK_BITS-1:0]   address_bank;
	logic [OFFSET_BITS-1:0] address_offset;
	logic [BUS_WIDTH-1:0]   write_upper;
	logic [BUS_WIDTH-1:0]   read_lower;
	logic                   data_phase;
	logic                   word_done;

	// ----------------------------------------
	// enable comes straight from the host pins
	always_ff @(posedge sysclk) begin
		if (reset) begin
			enable_meta <= 1'b0;
			enable_sync <= 1'b0;
		end else begin
			enable_meta <= enable;
			enable_sync <= enable_meta;
		end
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (enable_sync) state <= EXECUTE; // synchronized rise
				EXECUTE: state <= ACK;
				ACK:     if (!enable_sync) state <= RELEASE; // host let go
				RELEASE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign ack_valid  = (state == ACK);
	assign data_phase = (state == EXECUTE) && register_select;
	assign word_done  = data_phase && half;

	// write strobe on the lower half, read strobe on the upper half
	always_comb begin
		write_strobe = '0;
		read_strobe  = '0;
		if (word_done && !read) begin
			write_strobe[address_bank] = 1'b1;
		end
		if (data_phase && !half && read) begin
			read_strobe[address_bank] = 1'b1;
		end
	end

	assign reg_access = '{
		bank:       address_bank,
		offset:     address_offset,
		write_data: {write_upper, host_data_in}
	};

	// ----------------------------------------
	// address register, half counter and return data
	always_ff @(posedge sysclk) begin
		if (reset) begin
			half           <= 1'b0;
			address_bank   <= '0;
			address_offset <= '0;
			host_data_out  <= '0;
		end else if (state == EXECUTE) begin
			if (!register_select) begin
				half <= 1'b0;
				if (read) begin
					// address readback
					host_data_out <= {address_bank,
						{(BUS_WIDTH-BANK_BITS-OFFSET_BITS){1'b0}}, address_offset};
				end else begin
					address_bank   <= host_data_in[BUS_WIDTH-1 -: BANK_BITS];
					address_offset <= host_data_in[OFFSET_BITS-1:0];
				end
			end else begin
				half <= !half;
				if (word_done) begin
					address_offset <= address_offset + 1'b1; // autoincrement
				end
				if (read) begin
					host_data_out <= half ? read_lower : read_data[DATA_WIDTH-1 -: BUS_WIDTH];
				end
			end
		end
	end

	// upper write half and lower read half wait here for the second phase
	always_ff @(posedge sysclk) begin
		if (data_phase && !half) begin
			write_upper <= host_data_in;
			read_lower  <= read_data[BUS_WIDTH-1:0];
		end
	end

endmodule

// ==== source/asic_daq_pkg.sv ====
package asic_daq_pkg;

	// ----------------------------------------
	// bus and register geometry
	localparam int BUS_WIDTH   = 16;
	localparam int DATA_WIDTH  = 32; // two bus transactions per word
	localparam int BANK_BITS   = 3;  // top bits of the address word
	localparam int OFFSET_BITS = 4;  // low bits of the address word

	// readout
	localparam int FIFO_DEPTH_LOG2 = 5;
	localparam logic [BUS_WIDTH-1:0] HEADER_WORD = 16'hA5A5;
	localparam logic [BUS_WIDTH-1:0] FOOTER_WORD = 16'h5A5A;

	// ----------------------------------------
	// banks 4 to 7 are unused and read as zero
	typedef enum logic [BANK_BITS-1:0] {
		SETTINGS  = 3'd0,
		STATUS    = 3'd1,
		PULSES    = 3'd2,
		FIFO_DATA = 3'd3
	} bank_e;

	typedef enum logic [1:0] {IDLE, EXECUTE, ACK, RELEASE} host_state_e;

	typedef enum logic [1:0] {HUNT, SHIFT, STORE} readout_state_e;

	// ----------------------------------------
	typedef struct packed {
		logic [BANK_BITS-1:0]   bank;
		logic [OFFSET_BITS-1:0] offset;
		logic [DATA_WIDTH-1:0]  write_data;
	} reg_access_t;

	typedef struct packed {
		logic [11:0] cmp_bias;
		logic [11:0] isel;
		logic [11:0] sb_bias;
		logic [11:0] db_bias;
	} asic_bias_t;

	typedef struct packed {
		logic dreset;
		logic legacy_serial;
		logic i2c_start;
		logic trigger;
	} command_pulses_t;

	typedef struct packed {
		logic       dreset_flag;
		logic       legacy_serial_flag;
		logic       i2c_flag;
		logic       trigger_flag;
		logic [7:0] trigger_count;
	} command_status_t;

	typedef struct packed {
		logic header;
		logic meat;
		logic footer;
	} readout_flags_t;

endpackage
